// File: build.f
common/motor_pkg.sv
spi/spi_target.sv
spi/config_regs.sv
motion/step_generator.sv
motion/phase_sequencer.sv
encoder/quad_encoder.sv
src/motor_core.sv
verif/motor_checker.sv
verif/tb_motor_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stepper core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_motor_core -f build.f -o sim_motor
./obj_dir/sim_motor > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi
echo "Simulation log is clean"

// File: verif/tb_motor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_motor_core;

  localparam int RESET_HOLD   = 256;
  localparam int HALF_SCK     = 4;   // CLK cycles per SCK half period
  localparam int FRAME_CYCLES = 2 * HALF_SCK * 40 + 16;
  localparam int FRAME_COUNT  = 50;
  localparam int ENC_STEPS    = 32;
  localparam int MARGIN       = 5000;

  logic        CLK;
  logic        rst_n;
  logic        sck;
  logic        cs_n;
  logic        copi;
  logic        enc_a;
  logic        enc_b;
  logic        halt;
  wire         cipo;
  wire         step_out;
  wire         dir_out;
  wire         move_done;
  wire         phase_a1;
  wire         phase_a2;
  wire         phase_b1;
  wire         phase_b2;
  logic        wr_stb;
  logic        rd_stb;
  logic        enc_stb;
  logic        enc_up;
  logic        enc_bad;
  logic        win_stb;
  logic [7:0]  bus_addr;
  logic [31:0] bus_wdata;
  logic [31:0] bus_rdata;
  int          checks;
  int          errors;
  integer      seed;
  int          enc_idx;
  int          budget = RESET_HOLD + FRAME_COUNT * FRAME_CYCLES + ENC_STEPS * 8 + 600 + MARGIN;

  motor_core #(.RESET_HOLD(RESET_HOLD), .ENC_WIDTH(32)) u_motor_core (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .sck       (sck),
    .cs_n      (cs_n),
    .copi      (copi),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .halt      (halt),
    .cipo      (cipo),
    .step_out  (step_out),
    .dir_out   (dir_out),
    .move_done (move_done),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2)
  );

  motor_checker #(.RESET_HOLD(RESET_HOLD)) u_motor_checker (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .halt      (halt),
    .step_out  (step_out),
    .dir_out   (dir_out),
    .move_done (move_done),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .enc_stb   (enc_stb),
    .enc_up    (enc_up),
    .enc_bad   (enc_bad),
    .win_stb   (win_stb),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .checks    (checks),
    .errors    (errors)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic tick();
    @(posedge CLK);
    #5;
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) tick();
  endtask

  // Mode 0, copi set while SCK is low, cipo taken just before each rise
  task automatic spi_frame(input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] tx;
    int i;
    tx    = {addr, wdata};
    rdata = 32'd0;
    cs_n  = 1'b0;
    for (i = 39; i >= 0; i--) begin
      copi = tx[i];
      wait_cycles(HALF_SCK);
      if (i < 32)
        rdata = {rdata[30:0], cipo};
      sck = 1'b1;
      wait_cycles(HALF_SCK);
      sck = 1'b0;
    end
    wait_cycles(HALF_SCK);
    cs_n = 1'b1;
    copi = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd_ignored;
    spi_frame(addr, data, rd_ignored);
    bus_addr  = addr;
    bus_wdata = data;
    wr_stb    = 1'b1;
    tick();
    wr_stb = 1'b0;
    wait_cycles(HALF_SCK);
  endtask

  task automatic reg_read(input logic [7:0] addr);
    logic [31:0] data;
    spi_frame(addr, 32'd0, data);
    bus_addr  = addr;
    bus_rdata = data;
    rd_stb    = 1'b1;
    tick();
    rd_stb = 1'b0;
    wait_cycles(HALF_SCK);
  endtask

  task automatic wait_move_done();
    while (move_done !== 1'b1)
      tick();
  endtask

  task automatic run_move(input int steps, input int period, input logic fwd);
    budget += steps * period;
    reg_write(motor_pkg::REG_STEP_PERIOD, period);
    reg_write(motor_pkg::REG_MOVE, {fwd, 7'd0, 24'(steps)});
    wait_move_done();
  endtask

  task automatic measure_pwm();
    win_stb = 1'b1;
    tick();
    win_stb = 1'b0;
    wait_cycles(260);  // Window is one PWM period
  endtask

  // A leads B, pins as {A, B}
  function automatic logic [1:0] gray_ab(input int idx);
    case (idx & 3)
      0:       return 2'b00;
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic enc_step(input logic up);
    enc_idx        = up ? enc_idx + 1 : enc_idx - 1;
    {enc_a, enc_b} = gray_ab(enc_idx);
    enc_up         = up;
    enc_stb        = 1'b1;
    tick();
    enc_stb = 1'b0;
    wait_cycles(7);
  endtask

  task automatic enc_double_change();
    enc_idx        = enc_idx + 2;  // Both pins flip at once
    {enc_a, enc_b} = gray_ab(enc_idx);
    enc_bad        = 1'b1;
    tick();
    enc_bad = 1'b0;
    wait_cycles(7);
  endtask

  initial begin : watchdog
    int waited;
    waited = 0;
    while (waited < budget) begin
      @(posedge CLK);
      waited++;
    end
    $display("Timeout: the run did not finish within %0d cycles", waited);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int n;
    int p;
    int code;
    int k;
    logic fwd;
    seed      = 32'h8c51;
    rst_n     = 1'b0;
    sck       = 1'b0;
    cs_n      = 1'b1;
    copi      = 1'b0;
    enc_a     = 1'b0;
    enc_b     = 1'b0;
    halt      = 1'b0;
    wr_stb    = 1'b0;
    rd_stb    = 1'b0;
    enc_stb   = 1'b0;
    enc_up    = 1'b0;
    enc_bad   = 1'b0;
    win_stb   = 1'b0;
    bus_addr  = 8'd0;
    bus_wdata = 32'd0;
    bus_rdata = 32'd0;
    enc_idx   = 0;
    repeat (2) @(posedge CLK);
    #5;
    rst_n = 1'b1;
    wait_cycles(RESET_HOLD + 4);  // Fixed stretch length
    reg_read(motor_pkg::REG_READ_STATUS);

    // PWM duty at position 0
    n = 1 + $unsigned($random(seed)) % 255;
    reg_write(motor_pkg::REG_CURRENT, n);
    reg_write(motor_pkg::REG_ENABLE, 32'd1);
    measure_pwm();
    reg_write(motor_pkg::REG_ENABLE, 32'd0);
    measure_pwm();

    // Long move, a second move command arrives while it runs
    n   = 40 + $unsigned($random(seed)) % 32;
    p   = 16 + $unsigned($random(seed)) % 40;
    fwd = 1'($random(seed));
    budget += n * p;
    reg_write(motor_pkg::REG_STEP_PERIOD, p);
    reg_write(motor_pkg::REG_MOVE, {fwd, 7'd0, 24'(n)});
    reg_write(motor_pkg::REG_MOVE, {~fwd, 7'd0, 24'd5});
    wait_move_done();
    reg_read(motor_pkg::REG_READ_STATUS);

    // Halt partway through
    budget += 6 * p;
    reg_write(motor_pkg::REG_MOVE, {1'b1, 7'd0, 24'd200});
    wait_cycles(5 * p);
    halt = 1'b1;
    wait_move_done();
    wait_cycles(2);
    halt = 1'b0;
    reg_read(motor_pkg::REG_READ_STATUS);

    for (code = 0; code < 8; code++) begin  // Code 7 clamps to 6
      reg_write(motor_pkg::REG_MICROSTEPS, code);
      n   = 1 + $unsigned($random(seed)) % 12;
      p   = 12 + $unsigned($random(seed)) % 8;
      fwd = 1'($random(seed));
      run_move(n, p, fwd);
      reg_read(motor_pkg::REG_READ_STATUS);
    end

    for (k = 0; k < ENC_STEPS; k++)
      enc_step(1'($random(seed)));
    reg_read(motor_pkg::REG_READ_ENC);
    enc_double_change();
    reg_read(motor_pkg::REG_READ_STATUS);

    wait_cycles(4);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/motor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module motor_checker #(
  parameter int RESET_HOLD = 256
) (
  input  wire        CLK,
  input  wire        rst_n,
  input  wire        halt,
  input  wire        step_out,
  input  wire        dir_out,
  input  wire        move_done,
  input  wire        phase_a1,
  input  wire        phase_a2,
  input  wire        phase_b1,
  input  wire        phase_b2,
  input  wire        wr_stb,     // Register write finished on SPI
  input  wire        rd_stb,     // Register read finished on SPI
  input  wire        enc_stb,
  input  wire        enc_up,
  input  wire        enc_bad,
  input  wire        win_stb,    // Start of a PWM measurement window
  input  wire [7:0]  bus_addr,
  input  wire [31:0] bus_wdata,
  input  wire [31:0] bus_rdata,
  output int         checks,
  output int         errors
);

  int          n_checks   = 0;
  int          n_errors   = 0;
  logic        m_enable   = 1'b0;
  logic [2:0]  m_mstep    = 3'd0;
  logic [7:0]  m_current  = 8'd0;
  logic [15:0] m_period   = 16'd100;
  logic [7:0]  m_pos      = 8'd0;
  int          m_enc      = 0;
  logic        m_fault    = 1'b0;
  logic        m_dir      = 1'b0;
  logic        active     = 1'b0;  // Model thinks a move is running
  logic        halted     = 1'b0;
  logic        done_due   = 1'b0;
  logic        halt_prev  = 1'b0;
  int          steps_left = 0;
  int          cycle      = 0;
  int          last_step  = -1;
  int          since_rst  = 0;
  int          win_left   = 0;
  int          hi_a1;
  int          hi_a2;
  int          hi_b1;
  int          hi_b2;

  assign checks = n_checks;
  assign errors = n_errors;

  // One step moves 64 >> code, codes above 6 behave as 6
  function automatic logic [7:0] pos_after_step(input logic [7:0] pos, input logic fwd,
                                                input logic [2:0] code);
    int inc;
    inc = 64 >> ((code > 3'd6) ? 6 : int'(code));
    return fwd ? pos + 8'(inc) : pos - 8'(inc);
  endfunction

  // Cosine peaks at 255 at position 0
  function automatic int expected_duty(input logic [7:0] cur, input logic en);
    return en ? (int'(cur) * 255) / 256 : 0;
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    case (addr)
      motor_pkg::REG_READ_ENC:    return m_enc;
      motor_pkg::REG_READ_STATUS: return {m_fault, !active, 22'd0, m_pos};
      default:                    return 32'd0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic report_problem(input string msg);
    n_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  always @(posedge CLK) begin
    cycle     = cycle + 1;
    since_rst = rst_n ? since_rst + 1 : 0;
    if (rst_n && since_rst < RESET_HOLD) begin  // Core still held by the stretcher
      compare("move_done", 32'd1, move_done);
      compare("step_out", 32'd0, step_out);
      compare("phases", 32'd0, {phase_a1, phase_a2, phase_b1, phase_b2});
    end
    if (done_due) begin
      compare("move_done", 32'd1, move_done);
      done_due = 1'b0;
    end
    if (halt_prev)
      compare("move_done", 32'd1, move_done);
    if (step_out === 1'b1) begin
      if (!active || halted || steps_left == 0) begin
        report_problem("step pulse outside a commanded move");
      end else begin
        if (last_step >= 0)
          compare("step_interval", (m_period < 16'd2) ? 32'd2 : m_period, cycle - last_step);
        compare("dir_out", m_dir, dir_out);
        last_step  = cycle;
        steps_left = steps_left - 1;
        m_pos      = pos_after_step(m_pos, m_dir, m_mstep);
        done_due   = (steps_left == 0);
      end
    end else if (active && move_done === 1'b1) begin
      if (!halted && steps_left != 0)
        report_problem($sformatf("move ended with %0d steps missing", steps_left));
      active = 1'b0;
    end
    if (win_left > 0) begin
      hi_a1    = hi_a1 + int'(phase_a1);
      hi_a2    = hi_a2 + int'(phase_a2);
      hi_b1    = hi_b1 + int'(phase_b1);
      hi_b2    = hi_b2 + int'(phase_b2);
      win_left = win_left - 1;
      if (win_left == 0) begin
        compare("phase_a1_high", expected_duty(m_current, m_enable), hi_a1);
        compare("phase_a2_high", 32'd0, hi_a2);
        compare("phase_b1_high", 32'd0, hi_b1);
        compare("phase_b2_high", 32'd0, hi_b2);
      end
    end
    if (win_stb) begin
      win_left = 256;  // One PWM period
      hi_a1    = 0;
      hi_a2    = 0;
      hi_b1    = 0;
      hi_b2    = 0;
    end
    if (wr_stb) begin
      case (bus_addr)
        motor_pkg::REG_ENABLE:      m_enable = bus_wdata[0];
        motor_pkg::REG_MICROSTEPS:  m_mstep = bus_wdata[2:0];
        motor_pkg::REG_CURRENT:     m_current = bus_wdata[7:0];
        motor_pkg::REG_STEP_PERIOD: m_period = bus_wdata[15:0];
        motor_pkg::REG_MOVE: begin
          if (!active && bus_wdata[23:0] != 24'd0) begin  // Busy or empty moves are dropped
            active     = 1'b1;
            halted     = 1'b0;
            m_dir      = bus_wdata[31];
            steps_left = int'(bus_wdata[23:0]);
            last_step  = -1;
          end
        end
        default: ;
      endcase
    end
    if (rd_stb)
      compare("rd_data", expected_read(bus_addr), bus_rdata);
    if (enc_stb)
      m_enc = enc_up ? m_enc + 1 : m_enc - 1;
    if (enc_bad)
      m_fault = 1'b1;
    if (halt && active)
      halted = 1'b1;
    halt_prev = halt;
  end

endmodule

`default_nettype wire

// File: src/motor_core.sv
`timescale 1ns/1ps
`default_nettype none

module motor_core #(
  parameter int RESET_HOLD = 256,
  parameter int ENC_WIDTH  = 32
) (
  input  wire  CLK,
  input  wire  rst_n,
  input  wire  sck,
  input  wire  cs_n,
  input  wire  copi,
  input  wire  enc_a,
  input  wire  enc_b,
  input  wire  halt,
  output logic cipo,
  output logic step_out,
  output logic dir_out,
  output logic move_done,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic [HOLD_W-1:0] hold_cnt;
  logic              hold_done;
  logic              core_rst_n;

  logic [motor_pkg::DATA_BITS-1:0] rd_data;
  logic [motor_pkg::DATA_BITS-1:0] rx_data;
  motor_pkg::reg_addr_e            rx_addr;
  logic                            addr_strobe;
  logic                            frame_strobe;

  logic        enable;
  logic [2:0]  microsteps;
  logic [7:0]  current;
  logic [15:0] step_period;
  logic        move_start;
  logic        move_dir;
  logic [23:0] move_steps;

  logic [motor_pkg::POS_BITS-1:0] position;
  logic signed [ENC_WIDTH-1:0]    enc_count;
  logic                           enc_fault;

  assign hold_done = (hold_cnt == HOLD_W'(RESET_HOLD));

  // Reset stretcher, released RESET_HOLD cycles after rst_n goes high
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      hold_cnt   <= '0;
      core_rst_n <= 1'b0;
    end else if (!hold_done) begin
      hold_cnt   <= hold_cnt + 1'b1;
      core_rst_n <= (hold_cnt == HOLD_W'(RESET_HOLD - 1));
    end
  end

  hold_keeps_reset: assert property (@(posedge CLK) disable iff (!rst_n)
    !hold_done |-> !core_rst_n);

  spi_target u_spi_target (
    .CLK          (CLK),
    .rst_n        (core_rst_n),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .rd_data      (rd_data),
    .cipo         (cipo),
    .addr_strobe  (addr_strobe),
    .frame_strobe (frame_strobe),
    .rx_addr      (rx_addr),
    .rx_data      (rx_data)
  );

  config_regs #(.ENC_WIDTH(ENC_WIDTH)) u_config_regs (
    .CLK          (CLK),
    .rst_n        (core_rst_n),
    .addr_strobe  (addr_strobe),
    .frame_strobe (frame_strobe),
    .rx_addr      (rx_addr),
    .rx_data      (rx_data),
    .enc_count    (enc_count),
    .enc_fault    (enc_fault),
    .move_done    (move_done),
    .position     (position),
    .rd_data      (rd_data),
    .enable       (enable),
    .microsteps   (microsteps),
    .current      (current),
    .step_period  (step_period),
    .move_start   (move_start),
    .move_dir     (move_dir),
    .move_steps   (move_steps)
  );

  step_generator u_step_generator (
    .CLK         (CLK),
    .rst_n       (core_rst_n),
    .move_start  (move_start),
    .move_dir    (move_dir),
    .move_steps  (move_steps),
    .step_period (step_period),
    .halt        (halt),
    .step        (step_out),
    .dir         (dir_out),
    .move_done   (move_done)
  );

  phase_sequencer u_phase_sequencer (
    .CLK        (CLK),
    .rst_n      (core_rst_n),
    .step       (step_out),   // Same pulse the host sees
    .dir        (dir_out),
    .microsteps (microsteps),
    .current    (current),
    .enable     (enable),
    .position   (position),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

  quad_encoder #(.ENC_WIDTH(ENC_WIDTH)) u_quad_encoder (
    .CLK   (CLK),
    .rst_n (core_rst_n),
    .enc_a (enc_a),
    .enc_b (enc_b),
    .count (enc_count),
    .fault (enc_fault)
  );

endmodule

`default_nettype wire

// File: encoder/quad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module quad_encoder #(
  parameter int ENC_WIDTH = 32
) (
  input  wire                         CLK,
  input  wire                         rst_n,
  input  wire                         enc_a,
  input  wire                         enc_b,
  output logic signed [ENC_WIDTH-1:0] count,
  output logic                        fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic [1:0] cur_ab;
  logic [1:0] prev_ab;
  logic [1:0] delta;
  logic       count_up;

  assign cur_ab   = {a_sync[1], b_sync[1]};
  assign delta    = cur_ab ^ prev_ab;
  // A leading B gives 00 10 11 01
  assign count_up = cur_ab[1] ^ prev_ab[0];

  // Pin synchronizers and last sampled state
  always_ff @(posedge CLK) begin
    a_sync  <= {a_sync[0], enc_a};
    b_sync  <= {b_sync[0], enc_b};
    prev_ab <= cur_ab;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      count <= '0;
      fault <= 1'b0;
    end else if (delta == 2'b11) begin
      fault <= 1'b1;  // Both lines moved, sticky
    end else if (delta != 2'b00) begin
      if (count_up)
        count <= count + 1'b1;
      else
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: motion/phase_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer (
  input  wire                             CLK,
  input  wire                             rst_n,
  input  wire                             step,
  input  wire                             dir,
  input  wire [2:0]                       microsteps,
  input  wire [7:0]                       current,
  input  wire                             enable,
  output logic [motor_pkg::POS_BITS-1:0]  position,
  output logic                            phase_a1,
  output logic                            phase_a2,
  output logic                            phase_b1,
  output logic                            phase_b2
);

  localparam int PB      = motor_pkg::POS_BITS;
  localparam int QUARTER = 2 ** (PB - 2);  // One full step

  logic [PB-1:0]                   step_inc;
  logic [PB-1:0]                   pos_b;
  logic [8:0]                      cos_a;    // {negative, magnitude}
  logic [8:0]                      cos_b;
  logic [15:0]                     prod_a;
  logic [15:0]                     prod_b;
  logic [7:0]                      duty_a;
  logic [7:0]                      duty_b;
  logic [motor_pkg::PWM_BITS-1:0]  pwm_cnt;

  // Fold a full-cycle position onto the quarter table
  function automatic logic [8:0] cos_lookup(input logic [PB-1:0] pos);
    logic [1:0] quad;
    logic [5:0] idx;
    logic [7:0] mag;
    quad = pos[PB-1:PB-2];
    idx  = pos[5:0];
    if (!quad[0])
      mag = motor_pkg::quarter_cos(idx);
    else if (idx == 6'd0)
      mag = 8'd0;  // Zero crossing at 64 and 192
    else
      mag = motor_pkg::quarter_cos(6'd0 - idx);
    return {quad[1] ^ quad[0], mag};
  endfunction

  assign step_inc = PB'(QUARTER) >> microsteps;
  assign pos_b    = position - PB'(QUARTER);  // B lags A by 90 degrees

  assign cos_a  = cos_lookup(position);
  assign cos_b  = cos_lookup(pos_b);
  assign prod_a = current * cos_a[7:0];
  assign prod_b = current * cos_b[7:0];
  assign duty_a = prod_a[15:8];
  assign duty_b = prod_b[15:8];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      position <= '0;
    end else if (step) begin
      if (dir)
        position <= position + step_inc;
      else
        position <= position - step_inc;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pwm_cnt  <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      pwm_cnt  <= pwm_cnt + 1'b1;  // Free running, wraps every 256
      phase_a1 <= enable && !cos_a[8] && (pwm_cnt < duty_a);
      phase_a2 <= enable &&  cos_a[8] && (pwm_cnt < duty_a);
      phase_b1 <= enable && !cos_b[8] && (pwm_cnt < duty_b);
      phase_b2 <= enable &&  cos_b[8] && (pwm_cnt < duty_b);
    end
  end

  bridge_a_safe: assert property (@(posedge CLK) disable iff (!rst_n)
    !(phase_a1 && phase_a2));

  bridge_b_safe: assert property (@(posedge CLK) disable iff (!rst_n)
    !(phase_b1 && phase_b2));

endmodule

`default_nettype wire

// File: motion/step_generator.sv
`timescale 1ns/1ps
`default_nettype none

module step_generator (
  input  wire        CLK,
  input  wire        rst_n,
  input  wire        move_start,
  input  wire        move_dir,
  input  wire [23:0] move_steps,
  input  wire [15:0] step_period,
  input  wire        halt,
  output logic       step,
  output logic       dir,
  output logic       move_done
);

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e      state;
  logic [15:0] period_eff;
  logic [15:0] per_cnt;    // Counts down to the next pulse
  logic [23:0] remaining;
  logic        accept;
  logic        fire;

  assign period_eff = (step_period < 16'd2) ? 16'd2 : step_period;
  assign accept     = move_start && (state == IDLE) && (move_steps != 24'd0) && !halt;
  assign fire       = (state == RUN) && (per_cnt == 16'd1) && (remaining != 24'd0);
  assign move_done  = (state == IDLE);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= IDLE;
      step      <= 1'b0;
      dir       <= 1'b0;
      per_cnt   <= 16'd0;
      remaining <= 24'd0;
    end else begin
      step <= fire && !halt;
      case (state)
        IDLE: begin
          if (accept) begin
            state     <= RUN;
            dir       <= move_dir;
            per_cnt   <= period_eff - 16'd1;  // First pulse lands period_eff after accept
            remaining <= move_steps;
          end
        end
        RUN: begin
          if (halt)
            state <= IDLE;
          else if (step && remaining == 24'd0)
            state <= IDLE;  // Last pulse just went out
          if (fire) begin
            per_cnt   <= period_eff;
            remaining <= remaining - 24'd1;
          end else if (per_cnt != 16'd0) begin
            per_cnt <= per_cnt - 16'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  step_in_run: assert property (@(posedge CLK) disable iff (!rst_n)
    step |-> (state == RUN));

  step_single: assert property (@(posedge CLK) disable iff (!rst_n)
    step |=> !step);

endmodule

`default_nettype wire

// File: spi/config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module config_regs #(
  parameter int ENC_WIDTH = 32
) (
  input  wire                             CLK,
  input  wire                             rst_n,
  input  wire                             addr_strobe,
  input  wire                             frame_strobe,
  input  wire motor_pkg::reg_addr_e       rx_addr,
  input  wire [motor_pkg::DATA_BITS-1:0]  rx_data,
  input  wire [ENC_WIDTH-1:0]             enc_count,
  input  wire                             enc_fault,
  input  wire                             move_done,
  input  wire [7:0]                       position,
  output logic [motor_pkg::DATA_BITS-1:0] rd_data,
  output logic                            enable,
  output logic [2:0]                      microsteps,
  output logic [7:0]                      current,
  output logic [15:0]                     step_period,
  output logic                            move_start,
  output logic                            move_dir,
  output logic [23:0]                     move_steps
);

  localparam int DW = motor_pkg::DATA_BITS;

  // Write side, registers update the cycle after frame_strobe
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      enable      <= 1'b0;
      microsteps  <= 3'd0;
      current     <= 8'd0;
      step_period <= 16'd100;
      move_start  <= 1'b0;
      move_dir    <= 1'b0;
      move_steps  <= 24'd0;
    end else begin
      move_start <= 1'b0;
      if (frame_strobe) begin
        case (rx_addr)
          motor_pkg::REG_ENABLE:      enable <= rx_data[0];
          motor_pkg::REG_MICROSTEPS: begin
            if (rx_data[2:0] > motor_pkg::MSTEP_MAX)
              microsteps <= 3'(motor_pkg::MSTEP_MAX);  // Clamp to 64 microsteps
            else
              microsteps <= rx_data[2:0];
          end
          motor_pkg::REG_CURRENT:     current <= rx_data[7:0];
          motor_pkg::REG_STEP_PERIOD: step_period <= rx_data[15:0];
          motor_pkg::REG_MOVE: begin
            move_start <= 1'b1;
            move_dir   <= rx_data[31];
            move_steps <= rx_data[23:0];
          end
          default: ;
        endcase
      end
    end
  end

  // Read side, latched while the host still clocks nothing out
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (addr_strobe) begin
      case (rx_addr)
        motor_pkg::REG_READ_ENC:    rd_data <= DW'($signed(enc_count));
        motor_pkg::REG_READ_STATUS: rd_data <= {enc_fault, move_done, 22'd0, position};
        default:                    rd_data <= '0;
      endcase
    end
  end

  mstep_in_range: assert property (@(posedge CLK) disable iff (!rst_n)
    microsteps <= 3'(motor_pkg::MSTEP_MAX));

endmodule

`default_nettype wire

// File: spi/spi_target.sv
`timescale 1ns/1ps
`default_nettype none

module spi_target (
  input  wire                             CLK,
  input  wire                             rst_n,
  input  wire                             sck,
  input  wire                             cs_n,
  input  wire                             copi,
  input  wire [motor_pkg::DATA_BITS-1:0]  rd_data,
  output logic                            cipo,
  output logic                            addr_strobe,
  output logic                            frame_strobe,
  output motor_pkg::reg_addr_e            rx_addr,
  output logic [motor_pkg::DATA_BITS-1:0] rx_data
);

  localparam int CNT_W = $clog2(motor_pkg::FRAME_BITS + 1);
  localparam int AB    = motor_pkg::ADDR_BITS;
  localparam int DB    = motor_pkg::DATA_BITS;
  localparam int FB    = motor_pkg::FRAME_BITS;

  logic [1:0]       sck_sync;
  logic [1:0]       cs_sync;
  logic [1:0]       copi_sync;
  logic             sck_prev;
  logic             sck_rise;
  logic             sck_fall;
  logic             selected;
  logic             shift_en;
  logic             tx_en;
  logic             tx_load;
  logic [CNT_W-1:0] bit_cnt;
  logic [DB-2:0]    rx_shift;  // Newest bit comes straight from copi
  logic [DB-1:0]    tx_shift;

  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign selected = ~cs_sync[1];
  assign shift_en = selected && sck_rise && (bit_cnt < CNT_W'(FB));
  // Data bits go out on the falls after the address byte
  assign tx_en    = selected && sck_fall && (bit_cnt >= CNT_W'(AB)) && (bit_cnt < CNT_W'(FB));

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sck_sync  <= 2'b00;
      cs_sync   <= 2'b11;  // Deselected
      copi_sync <= 2'b00;
      sck_prev  <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      copi_sync <= {copi_sync[0], copi};
      sck_prev  <= sck_sync[1];
    end
  end

  // Bit counter and strobes
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      bit_cnt      <= '0;
      addr_strobe  <= 1'b0;
      frame_strobe <= 1'b0;
    end else begin
      addr_strobe  <= 1'b0;
      frame_strobe <= 1'b0;
      if (!selected) begin
        bit_cnt <= '0;  // Short frame dropped here
      end else if (shift_en) begin
        bit_cnt      <= bit_cnt + 1'b1;
        addr_strobe  <= (bit_cnt == CNT_W'(AB - 1));
        frame_strobe <= (bit_cnt == CNT_W'(FB - 1));
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (shift_en) begin
      rx_shift <= {rx_shift[DB-3:0], copi_sync[1]};
      if (bit_cnt == CNT_W'(AB - 1))
        rx_addr <= motor_pkg::reg_addr_e'({rx_shift[AB-2:0], copi_sync[1]});
      if (bit_cnt == CNT_W'(FB - 1))
        rx_data <= {rx_shift, copi_sync[1]};
    end
  end

  // Read data arrives the cycle after addr_strobe
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tx_load <= 1'b0;
      cipo    <= 1'b0;
    end else begin
      tx_load <= addr_strobe;
      if (!selected)
        cipo <= 1'b0;
      else if (tx_en)
        cipo <= tx_shift[DB-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (tx_load)
      tx_shift <= rd_data;
    else if (tx_en)
      tx_shift <= {tx_shift[DB-2:0], 1'b0};
  end

  strobes_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
    !(addr_strobe && frame_strobe));

endmodule

`default_nettype wire

// File: common/motor_pkg.sv
`default_nettype none

package motor_pkg;

  // Register map
  typedef enum logic [7:0] {
    REG_ENABLE      = 8'h01,
    REG_MICROSTEPS  = 8'h02,
    REG_CURRENT     = 8'h03,
    REG_STEP_PERIOD = 8'h04,
    REG_MOVE        = 8'h05,
    REG_READ_ENC    = 8'h10,
    REG_READ_STATUS = 8'h11
  } reg_addr_e;

  localparam int FRAME_BITS = 40;  // Address byte then data word
  localparam int ADDR_BITS  = 8;
  localparam int DATA_BITS  = 32;

  localparam int POS_BITS  = 8;  // 256 positions per electrical cycle
  localparam int PWM_BITS  = 8;
  localparam int MSTEP_MAX = 6;  // 64 microsteps

  // Quarter-wave cosine, index 64 is the quadrant boundary and reads as 0
  // Polynomial fit 1 - 1.2337 t^2 + 0.2337 t^4 with t = idx / 64
  function automatic logic [7:0] quarter_cos(input logic [5:0] idx);
    int sq;
    int amp;
    sq  = int'(idx) * int'(idx);
    amp = 255 - (315 * sq) / 4096 + (60 * sq * sq) / 16777216;
    return amp[7:0];
  endfunction

endpackage

`default_nettype wire
